//--- all.f
axi_pkg.sv
mon_pkg.sv
axi_addr_checker.sv
axi_data_checker.sv
axi_txn_counter.sv
mon_error_log.sv
mon_wb_regs.sv
axi_monitor_top.sv
tb_axi_monitor.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_axi_monitor -f all.f -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0

//--- tb_axi_monitor.sv
// Self-checking testbench for the AXI4 monitor; bursts stay at 16 beats or fewer
`timescale 1ns/100ps

module tb_axi_monitor;

    localparam logic [2:0] k_write  = 3'd0;
    localparam logic [2:0] k_read   = 3'd1;
    localparam logic [2:0] k_drop   = 3'd2;
    localparam logic [2:0] k_change = 3'd3;
    localparam logic [2:0] k_both   = 3'd4;
    localparam logic [1:0] incr     = 2'b01;
    localparam logic [1:0] wrap     = 2'b10;
    localparam int num_rows    = 22;
    localparam int cycle_limit = num_rows * (17 + 30) + 10;

    typedef struct packed {
        logic [2:0]  kind;
        logic [3:0]  chan;
        logic [3:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
        logic        lock;
        logic        stall;
    } row_t;

    logic        axi, rst;
    logic        awvalid, awready, awlock, arvalid, arready, arlock;
    logic [3:0]  awid, arid, bid, rid;
    logic [31:0] awaddr, araddr;
    logic [7:0]  awlen, arlen;
    logic [2:0]  awsize, arsize;
    logic [1:0]  awburst, arburst, bresp, rresp;
    logic        wvalid, wready, wlast, bvalid, bready, rvalid, rready, rlast;
    logic [63:0] wdata, rdata;
    logic        wb_cyc, wb_stb, wb_we, wb_ack, protocol_error;
    logic [2:0]  wb_adr;
    logic [31:0] wb_dat_o;

    row_t        rows [0:num_rows-1];
    logic [31:0] exp_write, exp_read, exp_bytes, exp_err, exp_rec;
    logic [15:0] lfsr;
    logic [63:0] wbase;
    logic        row_fail;
    int          pass_count, fail_count, cycles;

    axi_monitor_top #(.ADDR_WIDTH(32), .ID_WIDTH(4)) uut (.*);

    initial begin
        axi = 1'b0;
        forever #10 axi = ~axi;
    end

    always @(posedge axi) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ========================================================================
    // Random data and reference model
    // ========================================================================
    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_word(output logic [63:0] w);
        for (int i = 0; i < 64; i++) begin
            w[i] = lfsr[15];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [31:0] burst_size(input row_t r);
        burst_size = (32'(r.len) + 32'd1) << r.size;
    endfunction

    function automatic logic [3:0] expect_burst_rule(input row_t r);
        logic [31:0] last;
        last = r.addr + burst_size(r) - 32'd1;
        if (last[31:12] != r.addr[31:12]) return mon_pkg::rule_cross_4kb;
        if (r.burst == wrap && !(r.len == 1 || r.len == 3 || r.len == 7 || r.len == 15))
            return mon_pkg::rule_wrap_len;
        if (r.lock && burst_size(r) > 32'd128) return mon_pkg::rule_excl_size;
        return mon_pkg::rule_none;
    endfunction

    task automatic log_error(input logic [3:0] chan, input logic [3:0] rule);
        exp_err = exp_err + 32'd1;
        exp_rec = {16'h0000, exp_err[7:0], chan, rule};
    endtask

    // ========================================================================
    // Bus drivers
    // ========================================================================
    task automatic drive_addr(input logic rd, input logic v, input logic rdy,
                              input logic [31:0] addr, input row_t r);
        if (rd) begin
            arvalid <= v; arready <= rdy; arid <= r.id; araddr <= addr;
            arlen <= r.len; arsize <= r.size; arburst <= r.burst; arlock <= r.lock;
        end else begin
            awvalid <= v; awready <= rdy; awid <= r.id; awaddr <= addr;
            awlen <= r.len; awsize <= r.size; awburst <= r.burst; awlock <= r.lock;
        end
    endtask

    // alt selects the changed payload
    task automatic drive_chan(input logic [3:0] chan, input logic v, input logic rdy,
                              input logic alt, input row_t r);
        case (chan)
            mon_pkg::chan_aw: drive_addr(1'b0, v, rdy, r.addr + (alt ? 32'd8 : 32'd0), r);
            mon_pkg::chan_ar: drive_addr(1'b1, v, rdy, r.addr + (alt ? 32'd8 : 32'd0), r);
            mon_pkg::chan_w: begin
                wvalid <= v; wready <= rdy; wlast <= 1'b1;
                wdata <= alt ? ~wbase : wbase;
            end
            mon_pkg::chan_b: begin
                bvalid <= v; bready <= rdy; bid <= r.id ^ {3'd0, alt};
            end
            default: begin
                rvalid <= v; rready <= rdy; rlast <= 1'b0; rid <= r.id ^ {3'd0, alt};
            end
        endcase
    endtask

    task automatic addr_phase(input logic rd, input row_t r);
        logic [3:0] rule;
        rule = expect_burst_rule(r);
        @(posedge axi) drive_addr(rd, 1'b1, !r.stall, r.addr, r);
        if (r.stall) @(posedge axi) drive_addr(rd, 1'b1, 1'b1, r.addr, r);
        @(posedge axi) drive_addr(rd, 1'b0, 1'b0, r.addr, r);
        exp_bytes = exp_bytes + burst_size(r);
        // Address rules fire in every cycle with valid high
        if (rule != mon_pkg::rule_none) begin
            repeat (r.stall ? 2 : 1) log_error(rd ? mon_pkg::chan_ar : mon_pkg::chan_aw, rule);
        end
    endtask

    task automatic data_phase(input logic rd, input row_t r);
        logic [63:0] d;
        for (int beat = 0; beat <= int'(r.len); beat++) begin
            rand_word(d);
            @(posedge axi);
            if (rd) begin
                rvalid <= 1'b1; rready <= !(r.stall && beat == 0); rdata <= d;
                rid <= r.id; rlast <= (beat == int'(r.len));
            end else begin
                wvalid <= 1'b1; wready <= !(r.stall && beat == 0); wdata <= d;
                wlast <= (beat == int'(r.len));
            end
            if (r.stall && beat == 0) @(posedge axi) begin
                rready <= 1'b1;
                wready <= 1'b1;
            end
        end
        @(posedge axi);
        rvalid <= 1'b0; rready <= 1'b0; rlast <= 1'b0;
        wvalid <= 1'b0; wready <= 1'b0; wlast <= 1'b0;
    endtask

    task automatic resp_phase(input row_t r);
        @(posedge axi) begin
            bvalid <= 1'b1; bready <= !r.stall; bid <= r.id; bresp <= 2'b00;
        end
        if (r.stall) @(posedge axi) bready <= 1'b1;
        @(posedge axi) begin
            bvalid <= 1'b0; bready <= 1'b0;
        end
    endtask

    task automatic run_row(input row_t r);
        rand_word(wbase);
        case (r.kind)
            k_write: begin
                addr_phase(1'b0, r);
                data_phase(1'b0, r);
                resp_phase(r);
                exp_write = exp_write + 32'd1;
            end
            k_read: begin
                addr_phase(1'b1, r);
                data_phase(1'b1, r);
                exp_read = exp_read + 32'd1;
            end
            k_drop: begin
                @(posedge axi) drive_chan(r.chan, 1'b1, 1'b0, 1'b0, r);
                @(posedge axi) drive_chan(r.chan, 1'b0, 1'b0, 1'b0, r);
                log_error(r.chan, mon_pkg::rule_valid_drop);
            end
            k_change: begin
                @(posedge axi) drive_chan(r.chan, 1'b1, 1'b0, 1'b0, r);
                @(posedge axi) drive_chan(r.chan, 1'b1, 1'b1, 1'b1, r);
                @(posedge axi) drive_chan(r.chan, 1'b0, 1'b0, 1'b1, r);
                log_error(r.chan, mon_pkg::rule_payload_change);
                // The changed beat still completes a handshake
                if (r.chan == mon_pkg::chan_aw || r.chan == mon_pkg::chan_ar)
                    exp_bytes = exp_bytes + burst_size(r);
                if (r.chan == mon_pkg::chan_b) exp_write = exp_write + 32'd1;
            end
            default: begin
                @(posedge axi) begin
                    drive_chan(mon_pkg::chan_aw, 1'b1, 1'b0, 1'b0, r);
                    drive_chan(mon_pkg::chan_ar, 1'b1, 1'b0, 1'b0, r);
                end
                @(posedge axi) begin
                    drive_chan(mon_pkg::chan_aw, 1'b0, 1'b0, 1'b0, r);
                    drive_chan(mon_pkg::chan_ar, 1'b0, 1'b0, 1'b0, r);
                end
                log_error(mon_pkg::chan_aw, mon_pkg::rule_valid_drop);
            end
        endcase
    endtask

    // ========================================================================
    // Wishbone access and checks
    // ========================================================================
    task automatic wb_access(input logic we, input logic [2:0] adr, output logic [31:0] data);
        @(posedge axi) begin
            wb_cyc <= 1'b1; wb_stb <= 1'b1; wb_we <= we; wb_adr <= adr;
        end
        @(negedge axi);
        while (!wb_ack) @(negedge axi);
        data = wb_dat_o;
        @(posedge axi) begin
            wb_cyc <= 1'b0; wb_stb <= 1'b0; wb_we <= 1'b0;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            row_fail = 1'b1;
        end
    endtask

    task automatic read_and_check;
        logic [31:0] d;
        wb_access(1'b0, mon_pkg::reg_write_count, d);
        check_value("write_count", d, exp_write);
        wb_access(1'b0, mon_pkg::reg_read_count, d);
        check_value("read_count", d, exp_read);
        wb_access(1'b0, mon_pkg::reg_byte_count, d);
        check_value("byte_count", d, exp_bytes);
        wb_access(1'b0, mon_pkg::reg_error_count, d);
        check_value("error_count", d, exp_err);
        wb_access(1'b0, mon_pkg::reg_last_error, d);
        check_value("last_error", d, exp_rec);
        @(negedge axi);
        check_value("protocol_error", {31'd0, protocol_error}, {31'd0, exp_err != 32'd0});
    endtask

    task automatic finish_test(input string name);
        $display("%s: %s", name, row_fail ? "failed" : "ok");
        if (row_fail) fail_count++;
        else pass_count++;
        row_fail = 1'b0;
    endtask

    initial begin
        logic [31:0] d;
        rst = 1'b1;
        {awvalid, awready, awlock, arvalid, arready, arlock} = '0;
        {awid, arid, bid, rid, awaddr, araddr, awlen, arlen} = '0;
        {awsize, arsize, awburst, arburst, bresp, rresp} = '0;
        {wvalid, wready, wlast, bvalid, bready, rvalid, rready, rlast} = '0;
        {wdata, rdata, wb_cyc, wb_stb, wb_we, wb_adr} = '0;
        {exp_write, exp_read, exp_bytes, exp_err, exp_rec} = '0;
        lfsr = 16'd1947;
        row_fail = 1'b0;
        pass_count = 0;
        fail_count = 0;
        cycles = 0;

        rows[0]  = '{k_write, 4'd0, 4'd1, 32'h1000, 8'd0, 3'd3, incr, 1'b0, 1'b0};
        rows[1]  = '{k_write, 4'd0, 4'd2, 32'h2000, 8'd3, 3'd2, incr, 1'b0, 1'b1};
        rows[2]  = '{k_read, 4'd0, 4'd3, 32'h3000, 8'd7, 3'd3, incr, 1'b0, 1'b0};
        rows[3]  = '{k_read, 4'd0, 4'd4, 32'h3100, 8'd15, 3'd1, incr, 1'b0, 1'b1};
        rows[4]  = '{k_write, 4'd0, 4'd5, 32'h4000, 8'd15, 3'd3, incr, 1'b0, 1'b0};
        rows[5]  = '{k_change, mon_pkg::chan_aw, 4'd2, 32'h5000, 8'd1, 3'd3, incr, 1'b0, 1'b0};
        rows[6]  = '{k_drop, mon_pkg::chan_aw, 4'd2, 32'h5000, 8'd1, 3'd3, incr, 1'b0, 1'b0};
        rows[7]  = '{k_change, mon_pkg::chan_w, 4'd2, 32'h0, 8'd0, 3'd3, incr, 1'b0, 1'b0};
        rows[8]  = '{k_drop, mon_pkg::chan_w, 4'd2, 32'h0, 8'd0, 3'd3, incr, 1'b0, 1'b0};
        rows[9]  = '{k_change, mon_pkg::chan_b, 4'd6, 32'h0, 8'd0, 3'd3, incr, 1'b0, 1'b0};
        rows[10] = '{k_drop, mon_pkg::chan_b, 4'd6, 32'h0, 8'd0, 3'd3, incr, 1'b0, 1'b0};
        rows[11] = '{k_change, mon_pkg::chan_ar, 4'd7, 32'h5100, 8'd1, 3'd2, incr, 1'b0, 1'b0};
        rows[12] = '{k_drop, mon_pkg::chan_ar, 4'd7, 32'h5100, 8'd1, 3'd2, incr, 1'b0, 1'b0};
        rows[13] = '{k_change, mon_pkg::chan_r, 4'd8, 32'h0, 8'd0, 3'd3, incr, 1'b0, 1'b0};
        rows[14] = '{k_drop, mon_pkg::chan_r, 4'd8, 32'h0, 8'd0, 3'd3, incr, 1'b0, 1'b0};
        rows[15] = '{k_write, 4'd0, 4'd1, 32'h0FF0, 8'd3, 3'd3, incr, 1'b0, 1'b0};
        rows[16] = '{k_read, 4'd0, 4'd2, 32'h6000, 8'd2, 3'd2, wrap, 1'b0, 1'b0};
        rows[17] = '{k_write, 4'd0, 4'd3, 32'h7000, 8'd15, 3'd4, incr, 1'b1, 1'b0};
        rows[18] = '{k_read, 4'd0, 4'd4, 32'h6100, 8'd3, 3'd3, wrap, 1'b0, 1'b0};
        rows[19] = '{k_read, 4'd0, 4'd5, 32'h7100, 8'd7, 3'd3, incr, 1'b1, 1'b0};
        rows[20] = '{k_both, 4'd0, 4'd9, 32'h8000, 8'd1, 3'd3, incr, 1'b0, 1'b0};
        rows[21] = '{k_write, 4'd0, 4'd1, 32'h1FF8, 8'd1, 3'd3, incr, 1'b0, 1'b1};

        repeat (3) @(posedge axi);
        rst <= 1'b0;
        @(negedge axi);
        check_value("wb_ack", {31'd0, wb_ack}, 32'd0);
        read_and_check();
        finish_test("reset");

        for (int i = 0; i < num_rows; i++) begin
            run_row(rows[i]);
            read_and_check();
            finish_test($sformatf("row %0d kind %0d chan %0d", i, rows[i].kind, rows[i].chan));
        end

        wb_access(1'b0, 3'd5, d);
        check_value("wb_dat_o", d, 32'd0);
        finish_test("unmapped address");
        wb_access(1'b1, mon_pkg::reg_write_count, d);
        read_and_check();
        finish_test("ignored write");

        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- axi_monitor_top.sv
// Passive AXI4 monitor; never drives the bus, ids, responses and rdata are observed only
`timescale 1ns/100ps

module axi_monitor_top #(
    parameter int ADDR_WIDTH = 32,
    parameter int ID_WIDTH   = 4
) (
    input  logic                            axi,
    input  logic                            rst,
    // ========================================================================
    // AXI4 inputs
    // ========================================================================
    input  logic                            awvalid,
    input  logic                            awready,
    input  logic [ID_WIDTH-1:0]             awid,
    input  logic [ADDR_WIDTH-1:0]           awaddr,
    input  logic [axi_pkg::len_width-1:0]   awlen,
    input  logic [axi_pkg::size_width-1:0]  awsize,
    input  logic [axi_pkg::burst_width-1:0] awburst,
    input  logic                            awlock,
    input  logic                            wvalid,
    input  logic                            wready,
    input  logic [axi_pkg::data_width-1:0]  wdata,
    input  logic                            wlast,
    input  logic                            bvalid,
    input  logic                            bready,
    input  logic [ID_WIDTH-1:0]             bid,
    input  logic [axi_pkg::resp_width-1:0]  bresp,
    input  logic                            arvalid,
    input  logic                            arready,
    input  logic [ID_WIDTH-1:0]             arid,
    input  logic [ADDR_WIDTH-1:0]           araddr,
    input  logic [axi_pkg::len_width-1:0]   arlen,
    input  logic [axi_pkg::size_width-1:0]  arsize,
    input  logic [axi_pkg::burst_width-1:0] arburst,
    input  logic                            arlock,
    input  logic                            rvalid,
    input  logic                            rready,
    input  logic [ID_WIDTH-1:0]             rid,
    input  logic [axi_pkg::data_width-1:0]  rdata,
    input  logic [axi_pkg::resp_width-1:0]  rresp,
    input  logic                            rlast,
    // ========================================================================
    // Wishbone slave and status
    // ========================================================================
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  logic [2:0]                      wb_adr,
    output logic [31:0]                     wb_dat_o,
    output logic                            wb_ack,
    output logic                            protocol_error
);

    logic                 aw_err, w_err, b_err, ar_err, r_err;
    logic [3:0]           aw_rule, w_rule, b_rule, ar_rule, r_rule;
    logic [31:0]          write_count, read_count, byte_count, error_count;
    mon_pkg::err_record_t last_error;

    axi_addr_checker #(.ADDR_WIDTH(ADDR_WIDTH)) aw_chk (
        .axi(axi), .rst(rst), .valid(awvalid), .ready(awready), .addr(awaddr),
        .len(awlen), .size(awsize), .burst(awburst), .lock(awlock),
        .err(aw_err), .rule(aw_rule)
    );

    axi_addr_checker #(.ADDR_WIDTH(ADDR_WIDTH)) ar_chk (
        .axi(axi), .rst(rst), .valid(arvalid), .ready(arready), .addr(araddr),
        .len(arlen), .size(arsize), .burst(arburst), .lock(arlock),
        .err(ar_err), .rule(ar_rule)
    );

    axi_data_checker #(.ID_WIDTH(ID_WIDTH)) data_chk (
        .axi(axi), .rst(rst),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .bvalid(bvalid), .bready(bready), .bid(bid),
        .rvalid(rvalid), .rready(rready), .rid(rid),
        .w_err(w_err), .b_err(b_err), .r_err(r_err),
        .w_rule(w_rule), .b_rule(b_rule), .r_rule(r_rule)
    );

    axi_txn_counter txn_cnt (
        .axi(axi), .rst(rst),
        .aw_fire(awvalid && awready), .ar_fire(arvalid && arready),
        .aw_len(awlen), .aw_size(awsize), .ar_len(arlen), .ar_size(arsize),
        .b_fire(bvalid && bready), .r_last_fire(rvalid && rready && rlast),
        .write_count(write_count), .read_count(read_count), .byte_count(byte_count)
    );

    mon_error_log err_log (
        .axi(axi), .rst(rst),
        .aw_err(aw_err), .w_err(w_err), .b_err(b_err), .ar_err(ar_err), .r_err(r_err),
        .aw_rule(aw_rule), .w_rule(w_rule), .b_rule(b_rule),
        .ar_rule(ar_rule), .r_rule(r_rule),
        .error_count(error_count), .last_error(last_error),
        .protocol_error(protocol_error)
    );

    mon_wb_regs wb_regs (
        .axi(axi), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
        .write_count(write_count), .read_count(read_count),
        .byte_count(byte_count), .error_count(error_count),
        .last_error(last_error)
    );

endmodule

//--- mon_wb_regs.sv
// Wishbone classic read-only slave with one-cycle ack; writes are acked and dropped
`timescale 1ns/100ps

module mon_wb_regs (
    input  logic                 axi,
    input  logic                 rst,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [2:0]           wb_adr,
    output logic [31:0]          wb_dat_o,
    output logic                 wb_ack,
    input  logic [31:0]          write_count,
    input  logic [31:0]          read_count,
    input  logic [31:0]          byte_count,
    input  logic [31:0]          error_count,
    input  mon_pkg::err_record_t last_error
);

    logic req;

    // New request seen while ack is low
    assign req = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge axi) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    // Data is captured on the edge that raises ack
    always_ff @(posedge axi) begin
        if (req) begin
            if (wb_we) begin
                wb_dat_o <= '0;
            end else begin
                case (wb_adr)
                    mon_pkg::reg_write_count: wb_dat_o <= write_count;
                    mon_pkg::reg_read_count:  wb_dat_o <= read_count;
                    mon_pkg::reg_byte_count:  wb_dat_o <= byte_count;
                    mon_pkg::reg_error_count: wb_dat_o <= error_count;
                    mon_pkg::reg_last_error:  wb_dat_o <= last_error.raw;
                    default:                  wb_dat_o <= '0;
                endcase
            end
        end
    end

endmodule

//--- mon_error_log.sv
// Counts cycles with any error; the record keeps only the lowest flagging channel
`timescale 1ns/100ps

module mon_error_log (
    input  logic                 axi,
    input  logic                 rst,
    input  logic                 aw_err,
    input  logic                 w_err,
    input  logic                 b_err,
    input  logic                 ar_err,
    input  logic                 r_err,
    input  logic [3:0]           aw_rule,
    input  logic [3:0]           w_rule,
    input  logic [3:0]           b_rule,
    input  logic [3:0]           ar_rule,
    input  logic [3:0]           r_rule,
    output logic [31:0]          error_count,
    output mon_pkg::err_record_t last_error,
    output logic                 protocol_error
);

    logic        any_err;
    logic [31:0] next_count;
    logic [3:0]  sel_chan;
    logic [3:0]  sel_rule;

    assign any_err    = aw_err || w_err || b_err || ar_err || r_err;
    assign next_count = error_count + 1'b1;

    // Priority follows channel code order
    always_comb begin
        sel_chan = '0;
        sel_rule = mon_pkg::rule_none;
        if (aw_err) begin
            sel_chan = mon_pkg::chan_aw;
            sel_rule = aw_rule;
        end else if (w_err) begin
            sel_chan = mon_pkg::chan_w;
            sel_rule = w_rule;
        end else if (b_err) begin
            sel_chan = mon_pkg::chan_b;
            sel_rule = b_rule;
        end else if (ar_err) begin
            sel_chan = mon_pkg::chan_ar;
            sel_rule = ar_rule;
        end else if (r_err) begin
            sel_chan = mon_pkg::chan_r;
            sel_rule = r_rule;
        end
    end

    always_ff @(posedge axi) begin
        if (rst) begin
            error_count <= '0;
            last_error  <= '0;
        end else if (any_err) begin
            error_count                <= next_count;
            last_error.fields.reserved <= '0;
            last_error.fields.seq      <= next_count[7:0];
            last_error.fields.chan     <= sel_chan;
            last_error.fields.rule     <= sel_rule;
        end
    end

    assign protocol_error = error_count != 32'd0;

endmodule

//--- axi_txn_counter.sv
// Statistics counters of 32 bits that wrap; bytes are counted at the address handshake
`timescale 1ns/100ps

module axi_txn_counter (
    input  logic                           axi,
    input  logic                           rst,
    input  logic                           aw_fire,
    input  logic                           ar_fire,
    input  logic [axi_pkg::len_width-1:0]  aw_len,
    input  logic [axi_pkg::size_width-1:0] aw_size,
    input  logic [axi_pkg::len_width-1:0]  ar_len,
    input  logic [axi_pkg::size_width-1:0] ar_size,
    input  logic                           b_fire,
    input  logic                           r_last_fire,
    output logic [31:0]                    write_count,
    output logic [31:0]                    read_count,
    output logic [31:0]                    byte_count
);

    logic [31:0] aw_add;
    logic [31:0] ar_add;

    assign aw_add = aw_fire ? 32'(axi_pkg::burst_bytes(aw_len, aw_size)) : 32'd0;
    assign ar_add = ar_fire ? 32'(axi_pkg::burst_bytes(ar_len, ar_size)) : 32'd0;

    always_ff @(posedge axi) begin
        if (rst) begin
            write_count <= '0;
            read_count  <= '0;
            byte_count  <= '0;
        end else begin
            if (b_fire) begin
                write_count <= write_count + 1'b1;
            end
            if (r_last_fire) begin
                read_count <= read_count + 1'b1;
            end
            // Both address channels may land together
            byte_count <= byte_count + aw_add + ar_add;
        end
    end

endmodule

//--- axi_data_checker.sv
// W, B and R hold and stability checks only; wdata, bid and rid are the watched payloads
`timescale 1ns/100ps

module axi_data_checker #(
    parameter int ID_WIDTH = 4
) (
    input  logic                           axi,
    input  logic                           rst,
    input  logic                           wvalid,
    input  logic                           wready,
    input  logic [axi_pkg::data_width-1:0] wdata,
    input  logic                           bvalid,
    input  logic                           bready,
    input  logic [ID_WIDTH-1:0]            bid,
    input  logic                           rvalid,
    input  logic                           rready,
    input  logic [ID_WIDTH-1:0]            rid,
    output logic                           w_err,
    output logic                           b_err,
    output logic                           r_err,
    output logic [3:0]                     w_rule,
    output logic [3:0]                     b_rule,
    output logic [3:0]                     r_rule
);

    logic                           w_wait;
    logic                           b_wait;
    logic                           r_wait;
    logic [axi_pkg::data_width-1:0] prev_wdata;
    logic [ID_WIDTH-1:0]            prev_bid;
    logic [ID_WIDTH-1:0]            prev_rid;

    // Set when the channel was stalled last cycle
    always_ff @(posedge axi) begin
        if (rst) begin
            w_wait <= 1'b0;
            b_wait <= 1'b0;
            r_wait <= 1'b0;
        end else begin
            w_wait <= wvalid && !wready;
            b_wait <= bvalid && !bready;
            r_wait <= rvalid && !rready;
        end
        prev_wdata <= wdata;
        prev_bid   <= bid;
        prev_rid   <= rid;
    end

    assign w_rule = mon_pkg::hold_rule(w_wait, wvalid, wdata == prev_wdata);
    assign b_rule = mon_pkg::hold_rule(b_wait, bvalid, bid == prev_bid);
    assign r_rule = mon_pkg::hold_rule(r_wait, rvalid, rid == prev_rid);

    assign w_err = w_rule != mon_pkg::rule_none;
    assign b_err = b_rule != mon_pkg::rule_none;
    assign r_err = r_rule != mon_pkg::rule_none;

endmodule

//--- axi_addr_checker.sv
// One AW or AR channel; needs ADDR_WIDTH above 12, burst rules only while valid is high
`timescale 1ns/100ps

module axi_addr_checker #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                             axi,
    input  logic                             rst,
    input  logic                             valid,
    input  logic                             ready,
    input  logic [ADDR_WIDTH-1:0]            addr,
    input  logic [axi_pkg::len_width-1:0]    len,
    input  logic [axi_pkg::size_width-1:0]   size,
    input  logic [axi_pkg::burst_width-1:0]  burst,
    input  logic                             lock,
    output logic                             err,
    output logic [3:0]                       rule
);

    localparam int page_bits = $clog2(axi_pkg::boundary_bytes);

    logic                             prev_valid;
    logic                             prev_ready;
    logic [ADDR_WIDTH-1:0]            prev_addr;
    logic [axi_pkg::bytes_width-1:0]  num_bytes;
    logic [ADDR_WIDTH-1:0]            last_addr;
    logic                             crosses;
    logic                             wrap_bad;
    logic                             excl_bad;

    always_ff @(posedge axi) begin
        if (rst) begin
            prev_valid <= 1'b0;
            prev_ready <= 1'b0;
        end else begin
            prev_valid <= valid;
            prev_ready <= ready;
        end
        prev_addr <= addr;
    end

    // ========================================================================
    // Burst rules
    // ========================================================================
    assign num_bytes = axi_pkg::burst_bytes(len, size);
    assign last_addr = addr + ADDR_WIDTH'(num_bytes) - 1'b1;
    assign crosses   = last_addr[ADDR_WIDTH-1:page_bits] != addr[ADDR_WIDTH-1:page_bits];
    assign wrap_bad  = (burst == axi_pkg::burst_wrap) &&
                       !(len inside {8'd1, 8'd3, 8'd7, 8'd15});
    assign excl_bad  = (lock == axi_pkg::lock_exclusive) &&
                       (num_bytes > axi_pkg::exclusive_max_bytes);

    // Lowest rule code wins
    always_comb begin
        rule = mon_pkg::hold_rule(prev_valid && !prev_ready, valid, addr == prev_addr);
        if (rule == mon_pkg::rule_none && valid) begin
            if (crosses) begin
                rule = mon_pkg::rule_cross_4kb;
            end else if (wrap_bad) begin
                rule = mon_pkg::rule_wrap_len;
            end else if (excl_bad) begin
                rule = mon_pkg::rule_excl_size;
            end
        end
    end

    assign err = rule != mon_pkg::rule_none;

endmodule

//--- mon_pkg.sv
// Monitor register map and error codes; channel codes are ordered by report priority
package mon_pkg;

    // Wishbone word addresses
    localparam logic [2:0] reg_write_count = 3'd0;
    localparam logic [2:0] reg_read_count  = 3'd1;
    localparam logic [2:0] reg_byte_count  = 3'd2;
    localparam logic [2:0] reg_error_count = 3'd3;
    localparam logic [2:0] reg_last_error  = 3'd4;

    // Lowest code wins when channels flag together
    localparam logic [3:0] chan_aw = 4'd1;
    localparam logic [3:0] chan_w  = 4'd2;
    localparam logic [3:0] chan_b  = 4'd3;
    localparam logic [3:0] chan_ar = 4'd4;
    localparam logic [3:0] chan_r  = 4'd5;

    localparam logic [3:0] rule_none           = 4'd0;
    localparam logic [3:0] rule_valid_drop     = 4'd1;
    localparam logic [3:0] rule_payload_change = 4'd2;
    localparam logic [3:0] rule_cross_4kb      = 4'd3;
    localparam logic [3:0] rule_wrap_len       = 4'd4;
    localparam logic [3:0] rule_excl_size      = 4'd5;

    typedef struct packed {
        logic [15:0] reserved;
        logic [7:0]  seq;
        logic [3:0]  chan;
        logic [3:0]  rule;
    } err_fields_t;

    typedef union packed {
        logic [31:0] raw;
        err_fields_t fields;
    } err_record_t;

    // Hold and stability rules shared by every channel
    function automatic logic [3:0] hold_rule(
        input logic waiting,
        input logic valid,
        input logic stable
    );
        if (waiting && !valid) begin
            return rule_valid_drop;
        end
        if (waiting && !stable) begin
            return rule_payload_change;
        end
        return rule_none;
    endfunction

endpackage

//--- axi_pkg.sv
// AXI4 encodings and limits; burst byte count assumes len_width 8 and size_width 3
package axi_pkg;

    // ========================================================================
    // Bus widths
    // ========================================================================
    localparam int data_width  = 64;
    localparam int len_width   = 8;
    localparam int size_width  = 3;
    localparam int burst_width = 2;
    localparam int resp_width  = 2;

    // Largest burst is 256 beats of 128 bytes
    localparam int bytes_width = 16;

    // ========================================================================
    // Encodings and protocol limits
    // ========================================================================
    localparam logic [burst_width-1:0] burst_incr = 2'b01;
    localparam logic [burst_width-1:0] burst_wrap = 2'b10;
    localparam logic                   lock_exclusive = 1'b1;

    localparam int boundary_bytes      = 4096;
    localparam int exclusive_max_bytes = 128;

    // Bytes moved by one burst
    function automatic logic [bytes_width-1:0] burst_bytes(
        input logic [len_width-1:0]  len,
        input logic [size_width-1:0] size
    );
        burst_bytes = ({{(bytes_width-len_width){1'b0}}, len} + 1'b1) << size;
    endfunction

endpackage
